// File: hw/core_mem_pkg.sv
package core_mem_pkg;

    // byte address and line geometry
    localparam int addr_w     = 64;
    localparam int line_bytes = 64;
    localparam int line_bits  = 512;

    // decode buffer wraps at 128 bytes
    localparam int buf_bytes    = 128;
    localparam int offset_w     = 7;
    localparam int window_bytes = 15;

    // fetch is wanted while fewer bytes than this are buffered
    localparam int refill_level = 16;

    localparam int word_bytes = 8;
    localparam int word_bits  = 64;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_waiting,
        fetch_active
    } fetch_state_t;

    typedef enum logic [2:0] {
        data_idle,
        data_read_req,
        data_read_wait,
        data_write_req,
        data_write_wait
    } data_state_t;

endpackage

// File: hw/fetch_offsets.sv
module fetch_offsets
    import core_mem_pkg::*;
(
    input  logic                bus,
    input  logic                rst_n,
    input  logic [addr_w-1:0]   entry,
    input  logic [addr_w-1:0]   redirect_target,
    input  logic                load_entry,
    input  logic                do_redirect,
    input  logic                line_in,
    input  logic [3:0]          consume,
    output logic [addr_w-1:0]   fetch_rip,
    output logic [5:0]          skip,
    output logic [offset_w-1:0] fetch_offset,
    output logic [offset_w-1:0] decode_offset,
    output logic [7:0]          fill
);

    // both offsets wrap modulo the buffer size
    assign fill = {1'b0, fetch_offset - decode_offset};

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            fetch_offset  <= '0;
            decode_offset <= '0;
        end else if (do_redirect) begin
            fetch_offset  <= '0;
            decode_offset <= '0;
        end else begin
            if (line_in) begin
                fetch_offset <= fetch_offset + offset_w'(line_bytes) - offset_w'(skip);
            end
            decode_offset <= decode_offset + offset_w'(consume);
        end
    end

    // line address and leading bytes to drop from the next line
    always_ff @(posedge bus) begin
        if (load_entry) begin
            fetch_rip <= {entry[addr_w-1:6], 6'b0};
            skip      <= entry[5:0];
        end else if (do_redirect) begin
            fetch_rip <= {redirect_target[addr_w-1:6], 6'b0};
            skip      <= redirect_target[5:0];
        end else if (line_in) begin
            fetch_rip <= fetch_rip + addr_w'(line_bytes);
            skip      <= '0;
        end
    end

endmodule

// File: hw/fetch_ctrl.sv
module fetch_ctrl
    import core_mem_pkg::*;
(
    input  logic              bus,
    input  logic              rst_n,
    input  logic              redirect,
    input  logic              ibus_reqack,
    input  logic              ibus_respcyc,
    input  logic [7:0]        fill,
    input  logic [addr_w-1:0] fetch_rip,
    output logic              ibus_reqcyc,
    output logic [addr_w-1:0] ibus_req,
    output logic              do_redirect,
    output logic              line_in
);

    fetch_state_t state;
    logic         pending;
    logic         resp_seen;

    assign resp_seen = ibus_respcyc && (state == fetch_active);

    // with nothing in flight a redirect applies at once,
    // otherwise it waits for the response and drops that line
    assign do_redirect = ((state == fetch_idle) && redirect)
                       || (resp_seen && (pending || redirect));
    assign line_in     = resp_seen && !pending && !redirect;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state       <= fetch_idle;
            ibus_reqcyc <= 1'b0;
            pending     <= 1'b0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (fill < refill_level && !redirect) begin
                        state       <= fetch_waiting;
                        ibus_reqcyc <= 1'b1;
                    end
                end
                fetch_waiting: begin
                    // reqcyc drops the cycle after the ack
                    if (ibus_reqack) begin
                        ibus_reqcyc <= 1'b0;
                        state       <= fetch_active;
                    end
                end
                fetch_active: begin
                    if (ibus_respcyc) begin
                        state <= fetch_idle;
                    end
                end
                default: state <= fetch_idle;
            endcase

            if (resp_seen) begin
                pending <= 1'b0;
            end else if (state != fetch_idle && redirect) begin
                pending <= 1'b1;
            end
        end
    end

    // line address follows fetch_rip until the request goes out
    always_ff @(posedge bus) begin
        if (state == fetch_idle) begin
            ibus_req <= fetch_rip;
        end
    end

endmodule

// File: hw/line_buffer.sv
module line_buffer
    import core_mem_pkg::*;
(
    input  logic                  bus,
    input  logic                  line_in,
    input  logic [line_bits-1:0]  resp,
    input  logic [5:0]            skip,
    input  logic [offset_w-1:0]   fetch_offset,
    input  logic [offset_w-1:0]   decode_offset,
    output logic [8*window_bytes-1:0] window
);

    logic [7:0] mem [buf_bytes];

    // bytes skip..63 land at fetch_offset onward, wrapping
    always_ff @(posedge bus) begin
        if (line_in) begin
            for (int i = 0; i < line_bytes; i++) begin
                if (i >= int'(skip)) begin
                    mem[offset_w'(fetch_offset + offset_w'(i) - offset_w'(skip))]
                        <= resp[line_bits-1-8*i -: 8];
                end
            end
        end
    end

    // window byte 0 sits in the top bits
    always_comb begin
        for (int j = 0; j < window_bytes; j++) begin
            window[8*(window_bytes-1-j) +: 8] = mem[offset_w'(decode_offset + offset_w'(j))];
        end
    end

endmodule

// File: hw/data_ctrl.sv
module data_ctrl
    import core_mem_pkg::*;
(
    input  logic              bus,
    input  logic              rst_n,
    input  logic              load_req,
    input  logic              store_req,
    input  logic              dbus_reqack,
    input  logic              dbus_respcyc,
    input  logic [addr_w-1:0] data_addr,
    output logic              dbus_reqcyc,
    output logic              dbus_write,
    output logic              capture,
    output logic              merge,
    output logic              load_valid,
    output logic              store_done,
    output logic              data_busy,
    output logic [addr_w-1:0] dbus_req,
    output logic [2:0]        word_index
);

    data_state_t state;
    logic        is_store;
    logic        read_resp;

    assign read_resp   = dbus_respcyc && (state == data_read_wait);
    assign dbus_reqcyc = (state == data_read_req) || (state == data_write_req);
    assign dbus_write  = (state == data_write_req);
    assign data_busy   = (state != data_idle);

    // line goes straight in for a load, merged for a store
    assign capture = read_resp && !is_store;
    assign merge   = read_resp && is_store;

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state      <= data_idle;
            is_store   <= 1'b0;
            load_valid <= 1'b0;
            store_done <= 1'b0;
        end else begin
            load_valid <= capture;
            store_done <= 1'b0;
            case (state)
                data_idle: begin
                    if (load_req || store_req) begin
                        is_store <= store_req;
                        state    <= data_read_req;
                    end
                end
                data_read_req: begin
                    if (dbus_reqack) begin
                        state <= data_read_wait;
                    end
                end
                data_read_wait: begin
                    if (dbus_respcyc) begin
                        state <= is_store ? data_write_req : data_idle;
                    end
                end
                data_write_req: begin
                    if (dbus_reqack) begin
                        state <= data_write_wait;
                    end
                end
                data_write_wait: begin
                    // write response data is ignored
                    if (dbus_respcyc) begin
                        store_done <= 1'b1;
                        state      <= data_idle;
                    end
                end
                default: state <= data_idle;
            endcase
        end
    end

    // address held for the whole sequence
    always_ff @(posedge bus) begin
        if (state == data_idle && (load_req || store_req)) begin
            dbus_req   <= {data_addr[addr_w-1:6], 6'b0};
            word_index <= data_addr[5:3];
        end
    end

endmodule

// File: hw/word_lane.sv
module word_lane
    import core_mem_pkg::*;
(
    input  logic                 bus,
    input  logic                 capture,
    input  logic                 merge,
    input  logic [line_bits-1:0] resp,
    input  logic [2:0]           word_index,
    input  logic [word_bits-1:0] store_data,
    output logic [line_bits-1:0] line_out,
    output logic [word_bits-1:0] load_data
);

    logic [line_bits-1:0] merged;
    int                   top_bit;

    // word k starts at byte 8k, first byte most significant
    assign top_bit = line_bits - 1 - 8 * word_bytes * int'(word_index);

    always_comb begin
        merged = resp;
        merged[top_bit -: word_bits] = store_data;
    end

    always_ff @(posedge bus) begin
        if (merge) begin
            line_out <= merged;
        end else if (capture) begin
            line_out <= resp;
        end
    end

    assign load_data = line_out[top_bit -: word_bits];

endmodule

// File: hw/core_mem_top.sv
module core_mem_top
    import core_mem_pkg::*;
(
    input  logic                      bus,
    input  logic                      rst_n,
    input  logic [addr_w-1:0]         entry,
    // instruction bus
    output logic                      ibus_reqcyc,
    output logic [addr_w-1:0]         ibus_req,
    input  logic                      ibus_reqack,
    input  logic                      ibus_respcyc,
    input  logic [line_bits-1:0]      ibus_resp,
    // data bus
    output logic                      dbus_reqcyc,
    output logic [addr_w-1:0]         dbus_req,
    output logic                      dbus_write,
    output logic [line_bits-1:0]      dbus_reqdata,
    input  logic                      dbus_reqack,
    input  logic                      dbus_respcyc,
    input  logic [line_bits-1:0]      dbus_resp,
    // redirect_target stays stable until the redirect is applied
    input  logic                      redirect,
    input  logic [addr_w-1:0]         redirect_target,
    input  logic [3:0]                consume,
    input  logic                      load_req,
    input  logic                      store_req,
    input  logic [addr_w-1:0]         data_addr,
    input  logic [word_bits-1:0]      store_data,
    output logic                      load_valid,
    output logic [word_bits-1:0]      load_data,
    output logic                      store_done,
    output logic                      data_busy,
    output logic [8*window_bytes-1:0] window,
    output logic [7:0]                fill
);

    logic [addr_w-1:0]    fetch_rip;
    logic [5:0]           skip;
    logic [offset_w-1:0]  fetch_offset;
    logic [offset_w-1:0]  decode_offset;
    logic                 load_entry;
    logic                 do_redirect;
    logic                 line_in;
    logic                 capture;
    logic                 merge;
    logic [2:0]           word_index;
    logic [word_bits-1:0] store_data_q;

    assign load_entry = !rst_n;

    // store word is captured when the request is accepted
    always_ff @(posedge bus) begin
        if (store_req && !data_busy) begin
            store_data_q <= store_data;
        end
    end

    fetch_offsets i_fetch_offsets (
        .bus(bus), .rst_n(rst_n), .entry(entry), .redirect_target(redirect_target),
        .load_entry(load_entry), .do_redirect(do_redirect), .line_in(line_in),
        .consume(consume), .fetch_rip(fetch_rip), .skip(skip),
        .fetch_offset(fetch_offset), .decode_offset(decode_offset), .fill(fill)
    );

    fetch_ctrl i_fetch_ctrl (
        .bus(bus), .rst_n(rst_n), .redirect(redirect),
        .ibus_reqack(ibus_reqack), .ibus_respcyc(ibus_respcyc),
        .fill(fill), .fetch_rip(fetch_rip),
        .ibus_reqcyc(ibus_reqcyc), .ibus_req(ibus_req),
        .do_redirect(do_redirect), .line_in(line_in)
    );

    line_buffer i_line_buffer (
        .bus(bus), .line_in(line_in), .resp(ibus_resp), .skip(skip),
        .fetch_offset(fetch_offset), .decode_offset(decode_offset), .window(window)
    );

    data_ctrl i_data_ctrl (
        .bus(bus), .rst_n(rst_n), .load_req(load_req), .store_req(store_req),
        .dbus_reqack(dbus_reqack), .dbus_respcyc(dbus_respcyc), .data_addr(data_addr),
        .dbus_reqcyc(dbus_reqcyc), .dbus_write(dbus_write),
        .capture(capture), .merge(merge),
        .load_valid(load_valid), .store_done(store_done), .data_busy(data_busy),
        .dbus_req(dbus_req), .word_index(word_index)
    );

    word_lane i_word_lane (
        .bus(bus), .capture(capture), .merge(merge), .resp(dbus_resp),
        .word_index(word_index), .store_data(store_data_q),
        .line_out(dbus_reqdata), .load_data(load_data)
    );

endmodule

// File: tb/clk_gen.sv
module clk_gen (
    output logic bus,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        bus = 1'b0;
        forever #2 bus = ~bus;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge bus);
        rst_n <= 1'b1;
    end

endmodule

// File: tb/mem_model.sv
module mem_model
    import core_mem_pkg::*;
(
    input  logic                 bus,
    input  logic                 rst_n,
    input  logic                 ibus_reqcyc,
    input  logic [addr_w-1:0]    ibus_req,
    output logic                 ibus_reqack,
    output logic                 ibus_respcyc,
    output logic [line_bits-1:0] ibus_resp,
    input  logic                 dbus_reqcyc,
    input  logic [addr_w-1:0]    dbus_req,
    input  logic                 dbus_write,
    input  logic [line_bits-1:0] dbus_reqdata,
    output logic                 dbus_reqack,
    output logic                 dbus_respcyc,
    output logic [line_bits-1:0] dbus_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    // lines written over the data bus, keyed by line address
    logic [line_bits-1:0] lines [logic [addr_w-1:0]];

    function automatic logic [line_bits-1:0] read_line(input logic [addr_w-1:0] line_addr);
        logic [line_bits-1:0] line;
        logic [addr_w-1:0]    a;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int i = 0; i < line_bytes; i++) begin
            a = line_addr + addr_w'(i);
            line[line_bits-1-8*i -: 8] = a[7:0] ^ a[15:8];
        end
        return line;
    endfunction

    initial begin
        ibus_reqack  = 1'b0;
        ibus_respcyc = 1'b0;
        ibus_resp    = '0;
        dbus_reqack  = 1'b0;
        dbus_respcyc = 1'b0;
        dbus_resp    = '0;
    end

    always begin : ibus_slave
        logic [addr_w-1:0] line_addr;
        @(posedge bus);
        if (rst_n && ibus_reqcyc) begin
            line_addr = ibus_req;
            repeat ($urandom_range(5, 0)) @(posedge bus);
            ibus_reqack <= 1'b1;
            @(posedge bus);
            ibus_reqack <= 1'b0;
            repeat ($urandom_range(5, 0)) @(posedge bus);
            ibus_resp    <= read_line(line_addr);
            ibus_respcyc <= 1'b1;
            @(posedge bus);
            ibus_respcyc <= 1'b0;
        end
    end

    always begin : dbus_slave
        logic [addr_w-1:0]    line_addr;
        logic                 is_write;
        logic [line_bits-1:0] wdata;
        @(posedge bus);
        if (rst_n && dbus_reqcyc) begin
            line_addr = dbus_req;
            is_write  = dbus_write;
            wdata     = dbus_reqdata;
            repeat ($urandom_range(5, 0)) @(posedge bus);
            dbus_reqack <= 1'b1;
            @(posedge bus);
            dbus_reqack <= 1'b0;
            repeat ($urandom_range(5, 0)) @(posedge bus);
            // a write replaces the whole stored line
            if (is_write) begin
                lines[line_addr] = wdata;
            end
            dbus_resp    <= read_line(line_addr);
            dbus_respcyc <= 1'b1;
            @(posedge bus);
            dbus_respcyc <= 1'b0;
        end
    end

endmodule

// File: tb/core_mem_tb.sv
module core_mem_tb
    import core_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        row_fill,
        row_stream,
        row_redirect,
        row_redirect_idle,
        row_load,
        row_store
    } row_kind_t;

    // data is the store word or the expected load word
    typedef struct packed {
        row_kind_t            kind;
        logic [addr_w-1:0]    addr;
        logic [word_bits-1:0] data;
        logic [15:0]          cycles;
    } row_t;

    localparam logic [addr_w-1:0]    entry_addr = 64'h0000_0000_0000_3a6b;
    localparam logic [word_bits-1:0] store_word = 64'h0123_4567_89ab_cdef;

    logic                      bus;
    logic                      rst_n;
    logic [addr_w-1:0]         entry;
    logic                      ibus_reqcyc;
    logic [addr_w-1:0]         ibus_req;
    logic                      ibus_reqack;
    logic                      ibus_respcyc;
    logic [line_bits-1:0]      ibus_resp;
    logic                      dbus_reqcyc;
    logic [addr_w-1:0]         dbus_req;
    logic                      dbus_write;
    logic [line_bits-1:0]      dbus_reqdata;
    logic                      dbus_reqack;
    logic                      dbus_respcyc;
    logic [line_bits-1:0]      dbus_resp;
    logic                      redirect;
    logic [addr_w-1:0]         redirect_target;
    logic [3:0]                consume;
    logic                      load_req;
    logic                      store_req;
    logic [addr_w-1:0]         data_addr;
    logic [word_bits-1:0]      store_data;
    logic                      load_valid;
    logic [word_bits-1:0]      load_data;
    logic                      store_done;
    logic                      data_busy;
    logic [8*window_bytes-1:0] window;
    logic [7:0]                fill;

    row_t              stim[$];
    logic [addr_w-1:0] cursor;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    clk_gen i_clk_gen (.bus(bus), .rst_n(rst_n));
    mem_model i_mem_model (.*);
    core_mem_top i_dut (.*);

    // memory contents where nothing was written
    function automatic logic [7:0] byte_at(input logic [addr_w-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic logic [word_bits-1:0] word_at(input logic [addr_w-1:0] a);
        logic [word_bits-1:0] w;
        w = '0;
        for (int i = 0; i < word_bytes; i++) begin
            w = {w[word_bits-9:0], byte_at({a[addr_w-1:3], 3'b0} + addr_w'(i))};
        end
        return w;
    endfunction

    function automatic void add_row(input row_kind_t kind, input logic [addr_w-1:0] addr,
                                    input logic [word_bits-1:0] data, input int cycles);
        stim.push_back(row_t'{kind, addr, data, cycles[15:0]});
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // one clock, inputs change on the rising edge, outputs read on the falling one
    task automatic tick(input logic [3:0] n);
        @(posedge bus);
        consume   <= n;
        redirect  <= 1'b0;
        load_req  <= 1'b0;
        store_req <= 1'b0;
        @(negedge bus);
    endtask

    // only the buffered bytes of the window are compared
    task automatic check_window();
        logic [8*window_bytes-1:0] want;
        logic [8*window_bytes-1:0] mask;
        want = '0;
        mask = '0;
        for (int j = 0; j < window_bytes; j++) begin
            if (j < int'(fill)) begin
                want[8*(window_bytes-1-j) +: 8] = byte_at(cursor + addr_w'(j));
                mask[8*(window_bytes-1-j) +: 8] = 8'hff;
            end
        end
        assert ((window & mask) == want)
        else report_fail($sformatf("Fail window: got %h expected %h", window & mask, want));
    endtask

    task automatic wait_for_fill();
        while (fill < 8'(window_bytes)) begin
            tick(4'd0);
        end
        check_window();
    endtask

    task automatic stream_bytes(input int cycles);
        logic [3:0] n;
        repeat (cycles) begin
            check_window();
            n = 4'($urandom_range(15, 1));
            if (8'(n) > fill) begin
                n = fill[3:0];
            end
            tick(n);
            // the DUT takes consume at the following edge
            tick(4'd0);
            cursor = cursor + addr_w'(n);
        end
    endtask

    // with in_flight the pulse lands while a line fetch is outstanding,
    // otherwise enough is buffered that no fetch is issued
    // fill drops to zero once the redirect has taken effect
    task automatic apply_redirect(input logic [addr_w-1:0] target, input logic in_flight);
        if (in_flight) begin
            while (!ibus_reqcyc) begin
                stream_bytes(1);
            end
        end else begin
            while (fill < 8'(refill_level)) begin
                tick(4'd0);
            end
        end
        @(posedge bus);
        consume         <= '0;
        redirect        <= 1'b1;
        redirect_target <= target;
        @(negedge bus);
        cursor = target;
        tick(4'd0);
        // nothing in flight, so the flush shows on the next cycle
        if (!in_flight) begin
            assert (fill == 8'd0)
            else report_fail($sformatf("Fail fill: got %h expected 00", fill));
        end
        while (fill != 8'd0) begin
            tick(4'd0);
        end
    endtask

    task automatic data_request(input row_t r);
        while (data_busy) begin
            tick(4'd0);
        end
        @(posedge bus);
        consume    <= '0;
        load_req   <= (r.kind == row_load);
        store_req  <= (r.kind == row_store);
        data_addr  <= r.addr;
        store_data <= r.data;
        @(negedge bus);
        tick(4'd0);
        while (!load_valid && !store_done) begin
            tick(4'd0);
        end
        assert (load_valid == (r.kind == row_load))
        else report_fail("data request ended with the wrong completion pulse");
        if (r.kind == row_load) begin
            assert (load_data == r.data)
            else report_fail($sformatf("Fail load_data: got %h expected %h", load_data, r.data));
        end
    endtask

    always @(posedge bus) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            report_fail($sformatf("timeout: run still busy after %0d cycles", cycle_count));
        end
    end

    initial begin
        void'($urandom(36581));
        entry           = entry_addr;
        redirect        = 1'b0;
        redirect_target = '0;
        consume         = '0;
        load_req        = 1'b0;
        store_req       = 1'b0;
        data_addr       = '0;
        store_data      = '0;
        cursor          = entry_addr;

        add_row(row_fill, '0, '0, 0);
        add_row(row_stream, '0, '0, 400);
        add_row(row_redirect, 64'h0000_0000_0002_5d17, '0, 0);
        add_row(row_fill, '0, '0, 0);
        add_row(row_stream, '0, '0, 300);
        // only two bytes of the first line after this target are used
        add_row(row_redirect_idle, 64'h0000_0000_0001_0f3e, '0, 0);
        add_row(row_fill, '0, '0, 0);
        add_row(row_load, 64'h0000_0000_0000_7f43, word_at(64'h7f43), 0);
        add_row(row_store, 64'h0000_0000_0000_4128, store_word, 0);
        add_row(row_load, 64'h0000_0000_0000_412f, store_word, 0);
        add_row(row_load, 64'h0000_0000_0000_4130, word_at(64'h4130), 0);
        add_row(row_stream, '0, '0, 200);
        cycle_limit = 300 * stim.size();

        @(negedge bus);
        while (rst_n !== 1'b1) begin
            @(negedge bus);
        end
        assert ({ibus_reqcyc, dbus_reqcyc, load_valid, store_done, data_busy} == 5'b0)
        else report_fail($sformatf(
            "Fail {ibus_reqcyc,dbus_reqcyc,load_valid,store_done,data_busy}: got %h expected 00",
            {ibus_reqcyc, dbus_reqcyc, load_valid, store_done, data_busy}));
        assert (fill == 8'd0)
        else report_fail($sformatf("Fail fill: got %h expected 00", fill));

        while (!ibus_reqcyc) begin
            tick(4'd0);
        end
        assert (ibus_req == {entry_addr[addr_w-1:6], 6'b0})
        else report_fail($sformatf("Fail ibus_req: got %h expected %h",
                                   ibus_req, {entry_addr[addr_w-1:6], 6'b0}));

        foreach (stim[i]) begin
            case (stim[i].kind)
                row_fill:          wait_for_fill();
                row_stream:        stream_bytes(int'(stim[i].cycles));
                row_redirect:      apply_redirect(stim[i].addr, 1'b1);
                row_redirect_idle: apply_redirect(stim[i].addr, 1'b0);
                default:           data_request(stim[i]);
            endcase
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: core_mem_top.f
hw/core_mem_pkg.sv
hw/fetch_offsets.sv
hw/fetch_ctrl.sv
hw/line_buffer.sv
hw/data_ctrl.sv
hw/word_lane.sv
hw/core_mem_top.sv
tb/clk_gen.sv
tb/mem_model.sv
tb/core_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_mem_tb \
    -f core_mem_top.f -o core_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_mem_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
